// File: exe_stage.f
hdl/exe_pkg.sv
hdl/exe_fwd_if.sv
hdl/operand_forward.sv
hdl/alu.sv
hdl/branch_unit.sv
hdl/exe_stage.sv
bench/exe_stage_props.sv
bench/tb_exe_stage.sv

// File: Makefile
# Verilator build and run of the execute stage testbench

VERILATOR ?= verilator
TOP       ?= tb_exe_stage
FLIST     ?= exe_stage.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert
SIM_ARGS  ?=

SRCS := $(filter-out +%,$(shell cat $(FLIST)))
SIM  := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: $(SIM)

$(SIM): $(FLIST) $(SRCS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(BUILD_DIR) -o V$(TOP)

# exit status of the simulator is the test result
run: $(SIM)
	./$(SIM) $(SIM_ARGS)

clean:
	rm -rf $(BUILD_DIR)

// File: bench/tb_exe_stage.sv
module tb_exe_stage;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int NUM_PACKETS = 400;
    localparam int CYCLE_LIMIT = 4 * NUM_PACKETS + 20;
    localparam exe_pkg::br_cond_t COND_LIST [9] = '{
        exe_pkg::BR_JIRL, exe_pkg::BR_B, exe_pkg::BR_BL, exe_pkg::BR_BEQ, exe_pkg::BR_BNE,
        exe_pkg::BR_BLT, exe_pkg::BR_BGE, exe_pkg::BR_BLTU, exe_pkg::BR_BGEU
    };

    typedef struct packed {
        logic               en0;
        exe_pkg::reg_addr_t rd0;
        exe_pkg::word_t     data0;
        logic               en1;
        exe_pkg::reg_addr_t rd1;
        exe_pkg::word_t     data1;
    } wb_exp_t;

    typedef struct packed {
        logic           flush;
        exe_pkg::word_t pc;
    } flush_exp_t;

    logic clk, rst, flush_in, en0, br0, src2_imm0, en1, src2_imm1;
    exe_pkg::br_cond_t  cond0;
    exe_pkg::alu_op_t   op0, op1;
    exe_pkg::reg_addr_t rd0, rj0, rk0, rd1, rj1, rk1;
    exe_pkg::word_t     imm0, pc0, pc_next0, rj_data0, rk_data0, imm1, rj_data1, rk_data1;
    logic               wb_en0, wb_en1, flush;
    exe_pkg::reg_addr_t wb_rd0, wb_rd1;
    exe_pkg::word_t     wb_data0, wb_data1, redirect_pc;

    // arch holds the reference state and rf mirrors what the DUT committed
    exe_pkg::word_t arch [32];
    exe_pkg::word_t before_prev [32];
    exe_pkg::word_t rf [32];
    logic           prev_mispredict;
    logic [31:0]    lfsr_state = 32'h43c4;
    wb_exp_t        wb_q [$];
    flush_exp_t     flush_q [$];
    int             cycles;

    exe_stage dut0 (.*);

    function automatic logic lfsr_step();
        logic fb;
        fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
        lfsr_state = {lfsr_state[30:0], fb};
        return fb;
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) v = {v[30:0], lfsr_step()};
        return v;
    endfunction

    // indices 0 to 7 so that packets depend on each other
    function automatic exe_pkg::reg_addr_t rand_reg();
        logic [31:0] v;
        v = rand_bits(3);
        return {2'b00, v[2:0]};
    endfunction

    function automatic exe_pkg::word_t read_arch(input exe_pkg::reg_addr_t idx);
        return (idx == 5'd0) ? 32'd0 : arch[idx];
    endfunction

    function automatic exe_pkg::word_t alu_ref(input exe_pkg::alu_op_t op,
                                               input exe_pkg::word_t a, input exe_pkg::word_t b);
        case (op)
            exe_pkg::ALU_ADD:  return a + b;
            exe_pkg::ALU_SUB:  return a - b;
            exe_pkg::ALU_SLT:  return {31'd0, $signed(a) < $signed(b)};
            exe_pkg::ALU_SLTU: return {31'd0, a < b};
            exe_pkg::ALU_AND:  return a & b;
            exe_pkg::ALU_OR:   return a | b;
            exe_pkg::ALU_XOR:  return a ^ b;
            exe_pkg::ALU_NOR:  return ~(a | b);
            exe_pkg::ALU_SLL:  return a << b[4:0];
            exe_pkg::ALU_SRL:  return a >> b[4:0];
            exe_pkg::ALU_SRA:  return exe_pkg::word_t'($signed(a) >>> b[4:0]);
            exe_pkg::ALU_LUI:  return b;
            default:           return '0;
        endcase
    endfunction

    function automatic exe_pkg::word_t branch_next(input exe_pkg::br_cond_t cond,
            input exe_pkg::word_t pc, input exe_pkg::word_t imm,
            input exe_pkg::word_t a, input exe_pkg::word_t b);
        logic taken;
        case (cond)
            exe_pkg::BR_BEQ:  taken = a == b;
            exe_pkg::BR_BNE:  taken = a != b;
            exe_pkg::BR_BLT:  taken = $signed(a) < $signed(b);
            exe_pkg::BR_BGE:  taken = $signed(a) >= $signed(b);
            exe_pkg::BR_BLTU: taken = a < b;
            exe_pkg::BR_BGEU: taken = a >= b;
            default:          taken = 1'b1;
        endcase
        if (taken) return ((cond == exe_pkg::BR_JIRL) ? a : pc) + imm;
        return pc + exe_pkg::INST_BYTES;
    endfunction

    // models the packet on the inputs in program order and returns the pc_next to drive
    function automatic exe_pkg::word_t ref_packet(input logic predict_ok);
        exe_pkg::word_t a0, b0, a1, b1, actual;
        logic           mis, link;
        wb_exp_t        e, tail;
        flush_exp_t     f;
        if (flush_in) begin
            // the packet one cycle ahead dies with this one
            arch = before_prev;
            if (wb_q.size() > 0) begin
                tail = wb_q.pop_back();
                tail.en0 = 1'b0;
                tail.en1 = 1'b0;
                wb_q.push_back(tail);
            end
        end
        before_prev = arch;
        a0 = read_arch(rj0);
        b0 = read_arch(rk0);
        a1 = read_arch(rj1);
        b1 = read_arch(rk1);
        actual = branch_next(cond0, pc0, imm0, a0, b0);
        mis = en0 && br0 && !predict_ok;
        link = (cond0 == exe_pkg::BR_BL) || (cond0 == exe_pkg::BR_JIRL);
        e.en0 = en0 && (!br0 || link);
        e.rd0 = rd0;
        e.data0 = br0 ? pc0 + exe_pkg::INST_BYTES : alu_ref(op0, a0, src2_imm0 ? imm0 : b0);
        e.en1 = en1 && !mis;
        e.rd1 = rd1;
        e.data1 = alu_ref(op1, a1, src2_imm1 ? imm1 : b1);
        if (flush_in || prev_mispredict) begin
            e.en0 = 1'b0;
            e.en1 = 1'b0;
            mis = 1'b0;
        end
        if (e.en0) arch[rd0] = e.data0;
        if (e.en1) arch[rd1] = e.data1;
        prev_mispredict = mis;
        f.flush = mis;
        f.pc = actual;
        wb_q.push_back(e);
        flush_q.push_back(f);
        return predict_ok ? actual : actual + 32'd8;
    endfunction

    task automatic fail_now(input string reason);
        $display("*** FAILED ***");
        $fatal(1, "%s", reason);
    endtask

    task automatic check_word(input string what, input exe_pkg::word_t got,
                              input exe_pkg::word_t exp);
        if (got !== exp) begin
            $display("[ERROR] %0d ns: %s is %h, expected %h", $time, what, got, exp);
            fail_now("wrong word value");
        end
    endtask

    task automatic check_addr(input string what, input exe_pkg::reg_addr_t got,
                              input exe_pkg::reg_addr_t exp);
        if (got !== exp) begin
            $display("[ERROR] %0d ns: %s is %0d, expected %0d", $time, what, got, exp);
            fail_now("wrong register index");
        end
    endtask

    task automatic check_bit(input string what, input logic got, input logic exp);
        if (got !== exp) begin
            $display("[ERROR] %0d ns: %s is %b, expected %b", $time, what, got, exp);
            fail_now("wrong control bit");
        end
    endtask

    task automatic drive_packet();
        logic [31:0] v;
        v = rand_bits(3);
        en0 = v[2:0] != 3'd0;
        v = rand_bits(3);
        en1 = v[2:0] != 3'd0;
        v = rand_bits(2);
        br0 = v[1:0] == 2'd0;
        cond0 = COND_LIST[int'(rand_bits(4) % 9)];
        op0 = exe_pkg::alu_op_t'(rand_bits(4) % 12);
        op1 = exe_pkg::alu_op_t'(rand_bits(4) % 12);
        rd0 = rand_reg();
        rj0 = rand_reg();
        rk0 = rand_reg();
        rd1 = rand_reg();
        rj1 = rand_reg();
        rk1 = rand_reg();
        v = rand_bits(1);
        // equal operands so that eq and ge style branches also take
        if (br0 && v[0]) rk0 = rj0;
        // lane 1 never reads what lane 0 writes
        if (rj1 == rd0) rj1 = rd0 ^ 5'd1;
        if (rk1 == rd0) rk1 = rd0 ^ 5'd1;
        v = rand_bits(2);
        src2_imm0 = v[0];
        src2_imm1 = v[1];
        v = rand_bits(1);
        if (br0 || v[0]) begin
            v = rand_bits(9);
            imm0 = {{22{v[8]}}, v[7:0], 2'b00};
        end else begin
            imm0 = rand_bits(32);
        end
        imm1 = rand_bits(32);
        v = rand_bits(16);
        pc0 = {14'd0, v[15:0], 2'b00};
        v = rand_bits(5);
        flush_in = v[4:0] == 5'd0;
        rj_data0 = rf[rj0];
        rk_data0 = rf[rk0];
        rj_data1 = rf[rj1];
        rk_data1 = rf[rk1];
        v = rand_bits(1);
        pc_next0 = ref_packet(v[0]);
    endtask

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    initial begin
        cycles = 0;
        while (cycles <= CYCLE_LIMIT) @(posedge clk) cycles++;
        $display("timeout: the writeback queue did not drain within %0d cycles", CYCLE_LIMIT);
        fail_now("simulation ran too long");
    end

    // outputs sampled at the edge hold the values of the cycle just ended
    always @(posedge clk) begin
        wb_exp_t    e;
        flush_exp_t f;
        if (!rst && flush_q.size() > 0) begin
            f = flush_q.pop_front();
            check_bit("flush", flush, f.flush);
            if (f.flush) check_word("redirect_pc", redirect_pc, f.pc);
        end
        if (!rst && wb_q.size() > 0) begin
            e = wb_q.pop_front();
            check_bit("wb_en0", wb_en0, e.en0);
            check_bit("wb_en1", wb_en1, e.en1);
            if (e.en0) check_addr("wb_rd0", wb_rd0, e.rd0);
            if (e.en0) check_word("wb_data0", wb_data0, e.data0);
            if (e.en1) check_addr("wb_rd1", wb_rd1, e.rd1);
            if (e.en1) check_word("wb_data1", wb_data1, e.data1);
        end
        if (!rst && wb_en0) rf[wb_rd0] = wb_data0;
        if (!rst && wb_en1) rf[wb_rd1] = wb_data1;
    end

    initial begin
        {flush_in, en0, br0, src2_imm0, en1, src2_imm1} = '0;
        {cond0, op0, op1, rd0, rj0, rk0, rd1, rj1, rk1} = '0;
        {imm0, pc0, pc_next0, rj_data0, rk_data0, imm1, rj_data1, rk_data1} = '0;
        prev_mispredict = 1'b0;
        for (int i = 0; i < 32; i++) begin
            rf[i] = 32'h9e37_79b9 * (i + 1);
            arch[i] = rf[i];
            before_prev[i] = rf[i];
        end
        rst = 1'b1;
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        @(negedge clk);
        // pipeline starts empty
        wb_q.push_back('0);
        wb_q.push_back('0);
        flush_q.push_back('0);
        for (int n = 0; n < NUM_PACKETS; n++) begin
            drive_packet();
            @(negedge clk);
        end
        {en0, en1, flush_in} = '0;
        while (wb_q.size() != 0 || flush_q.size() != 0) @(negedge clk);
        $display("*** PASSED ***");
        $finish;
    end

endmodule

// File: bench/exe_stage_props.sv
module exe_stage_props (
    input logic clk,
    input logic rst,
    input logic flush,
    input logic wb_en0,
    input logic wb_en1
);

    timeunit 1ns;
    timeprecision 1ps;

    // redirect lasts exactly one cycle
    single_flush: assert property (
        @(posedge clk) disable iff (rst) flush |=> !flush
    ) else $error("flush high in two consecutive cycles");

    // lane 1 of the mispredicted packet never writes back
    squash_lane1: assert property (
        @(posedge clk) disable iff (rst) flush |=> !wb_en1
    ) else $error("wb_en1 high in the cycle after flush");

    quiet_after_reset: assert property (
        @(posedge clk) ($past(rst) || $past(rst, 2)) |-> !wb_en0 && !wb_en1 && !flush
    ) else $error("writeback or flush active during or just after reset");

endmodule

bind exe_stage exe_stage_props props0 (
    .clk    (clk),
    .rst    (rst),
    .flush  (flush),
    .wb_en0 (wb_en0),
    .wb_en1 (wb_en1)
);

// File: hdl/exe_stage.sv
module exe_stage (
    input  logic                clk,
    input  logic                rst,
    input  logic                flush_in,

    // lane 0
    input  logic                en0,
    input  logic                br0,
    input  exe_pkg::br_cond_t   cond0,
    input  exe_pkg::alu_op_t    op0,
    input  exe_pkg::reg_addr_t  rd0,
    input  exe_pkg::reg_addr_t  rj0,
    input  exe_pkg::reg_addr_t  rk0,
    input  logic                src2_imm0,
    input  exe_pkg::word_t      imm0,
    input  exe_pkg::word_t      pc0,
    input  exe_pkg::word_t      pc_next0,
    input  exe_pkg::word_t      rj_data0,
    input  exe_pkg::word_t      rk_data0,

    // lane 1
    input  logic                en1,
    input  exe_pkg::alu_op_t    op1,
    input  exe_pkg::reg_addr_t  rd1,
    input  exe_pkg::reg_addr_t  rj1,
    input  exe_pkg::reg_addr_t  rk1,
    input  logic                src2_imm1,
    input  exe_pkg::word_t      imm1,
    input  exe_pkg::word_t      rj_data1,
    input  exe_pkg::word_t      rk_data1,

    // writeback
    output logic                wb_en0,
    output exe_pkg::reg_addr_t  wb_rd0,
    output exe_pkg::word_t      wb_data0,
    output logic                wb_en1,
    output exe_pkg::reg_addr_t  wb_rd1,
    output exe_pkg::word_t      wb_data1,

    // redirect to fetch
    output logic                flush,
    output exe_pkg::word_t      redirect_pc
);

    exe_fwd_if s1_fwd ();
    exe_fwd_if s2_fwd ();

    exe_pkg::word_t src_a0;
    exe_pkg::word_t src_b0;
    exe_pkg::word_t src_a1;
    exe_pkg::word_t src_b1;
    exe_pkg::word_t alu_b0;
    exe_pkg::word_t alu_b1;
    exe_pkg::word_t alu_res0;
    exe_pkg::word_t alu_res1;

    logic           link_en;
    exe_pkg::word_t link_data;
    exe_pkg::word_t br_next_pc;
    logic           br_mispredict;

    logic           br_valid;
    logic           res_en0;
    exe_pkg::word_t res_data0;

    logic           s1_mispredict;
    exe_pkg::word_t s1_next_pc;

    operand_forward fwd_unit (
        .rj0      (rj0),
        .rk0      (rk0),
        .rj1      (rj1),
        .rk1      (rk1),
        .rj_data0 (rj_data0),
        .rk_data0 (rk_data0),
        .rj_data1 (rj_data1),
        .rk_data1 (rk_data1),
        .s1       (s1_fwd.sink),
        .s2       (s2_fwd.sink),
        .src_a0   (src_a0),
        .src_b0   (src_b0),
        .src_a1   (src_a1),
        .src_b1   (src_b1)
    );

    assign alu_b0 = src2_imm0 ? imm0 : src_b0;
    assign alu_b1 = src2_imm1 ? imm1 : src_b1;

    alu alu0 (
        .op     (op0),
        .a      (src_a0),
        .b      (alu_b0),
        .result (alu_res0)
    );

    alu alu1 (
        .op     (op1),
        .a      (src_a1),
        .b      (alu_b1),
        .result (alu_res1)
    );

    // branches compare raw rk, never the immediate
    branch_unit br_unit (
        .cond       (cond0),
        .pc         (pc0),
        .pc_next    (pc_next0),
        .imm        (imm0),
        .src_a      (src_a0),
        .src_b      (src_b0),
        .link_en    (link_en),
        .link_data  (link_data),
        .next_pc    (br_next_pc),
        .mispredict (br_mispredict)
    );

    assign br_valid  = en0 && br0;
    assign res_en0   = en0 && (!br0 || link_en);
    assign res_data0 = br0 ? link_data : alu_res0;

    // stage 1 control, drops the packet arriving under a flush
    always_ff @(posedge clk) begin
        if (rst || flush_in || flush) begin
            s1_fwd.en0    <= 1'b0;
            s1_fwd.en1    <= 1'b0;
            s1_mispredict <= 1'b0;
        end else begin
            s1_fwd.en0    <= res_en0;
            s1_fwd.en1    <= en1;
            s1_mispredict <= br_valid && br_mispredict;
        end
    end

    always_ff @(posedge clk) begin
        s1_fwd.rd0   <= rd0;
        s1_fwd.data0 <= res_data0;
        s1_fwd.rd1   <= rd1;
        s1_fwd.data1 <= alu_res1;
        s1_next_pc   <= br_next_pc;
    end

    // stage 2, lane 1 of a mispredicted branch packet is squashed
    always_ff @(posedge clk) begin
        if (rst || flush_in) begin
            s2_fwd.en0 <= 1'b0;
            s2_fwd.en1 <= 1'b0;
        end else begin
            s2_fwd.en0 <= s1_fwd.en0;
            s2_fwd.en1 <= s1_fwd.en1 && !flush;
        end
    end

    always_ff @(posedge clk) begin
        s2_fwd.rd0   <= s1_fwd.rd0;
        s2_fwd.data0 <= s1_fwd.data0;
        s2_fwd.rd1   <= s1_fwd.rd1;
        s2_fwd.data1 <= s1_fwd.data1;
    end

    assign flush       = s1_mispredict;
    assign redirect_pc = s1_next_pc;

    assign wb_en0   = s2_fwd.en0;
    assign wb_rd0   = s2_fwd.rd0;
    assign wb_data0 = s2_fwd.data0;
    assign wb_en1   = s2_fwd.en1;
    assign wb_rd1   = s2_fwd.rd1;
    assign wb_data1 = s2_fwd.data1;

endmodule

// File: hdl/branch_unit.sv
module branch_unit (
    input  exe_pkg::br_cond_t cond,
    input  exe_pkg::word_t    pc,
    input  exe_pkg::word_t    pc_next,
    input  exe_pkg::word_t    imm,
    input  exe_pkg::word_t    src_a,
    input  exe_pkg::word_t    src_b,
    output logic              link_en,
    output exe_pkg::word_t    link_data,
    output exe_pkg::word_t    next_pc,
    output logic              mispredict
);

    logic           taken;
    exe_pkg::word_t base;
    exe_pkg::word_t target;
    exe_pkg::word_t fall_through;

    always_comb begin
        case (cond)
            exe_pkg::BR_JIRL,
            exe_pkg::BR_B,
            exe_pkg::BR_BL:   taken = 1'b1;
            exe_pkg::BR_BEQ:  taken = src_a == src_b;
            exe_pkg::BR_BNE:  taken = src_a != src_b;
            exe_pkg::BR_BLT:  taken = $signed(src_a) < $signed(src_b);
            exe_pkg::BR_BGE:  taken = $signed(src_a) >= $signed(src_b);
            exe_pkg::BR_BLTU: taken = src_a < src_b;
            exe_pkg::BR_BGEU: taken = src_a >= src_b;
            default:          taken = 1'b0;
        endcase
    end

    // jirl is register relative, everything else pc relative
    assign base         = (cond == exe_pkg::BR_JIRL) ? src_a : pc;
    assign target       = base + imm;
    assign fall_through = pc + exe_pkg::INST_BYTES;

    assign next_pc    = taken ? target : fall_through;
    assign mispredict = next_pc != pc_next;

    // return address for calls
    assign link_en   = (cond == exe_pkg::BR_BL) || (cond == exe_pkg::BR_JIRL);
    assign link_data = fall_through;

endmodule

// File: hdl/alu.sv
module alu (
    input  exe_pkg::alu_op_t op,
    input  exe_pkg::word_t   a,
    input  exe_pkg::word_t   b,
    output exe_pkg::word_t   result
);

    logic [exe_pkg::SHAMT_BITS-1:0] shamt;
    logic                           lt_signed;
    logic                           lt_unsigned;

    assign shamt       = b[exe_pkg::SHAMT_BITS-1:0];
    assign lt_signed   = $signed(a) < $signed(b);
    assign lt_unsigned = a < b;

    always_comb begin
        case (op)
            exe_pkg::ALU_ADD:  result = a + b;
            exe_pkg::ALU_SUB:  result = a - b;
            // compares give a single bit, zero extended
            exe_pkg::ALU_SLT:  result = exe_pkg::word_t'(lt_signed);
            exe_pkg::ALU_SLTU: result = exe_pkg::word_t'(lt_unsigned);
            exe_pkg::ALU_AND:  result = a & b;
            exe_pkg::ALU_OR:   result = a | b;
            exe_pkg::ALU_XOR:  result = a ^ b;
            exe_pkg::ALU_NOR:  result = ~(a | b);
            exe_pkg::ALU_SLL:  result = a << shamt;
            exe_pkg::ALU_SRL:  result = a >> shamt;
            exe_pkg::ALU_SRA:  result = exe_pkg::word_t'($signed(a) >>> shamt);
            // immediate already shifted by decode
            exe_pkg::ALU_LUI:  result = b;
            default:           result = '0;
        endcase
    end

endmodule

// File: hdl/operand_forward.sv
module operand_forward (
    input  exe_pkg::reg_addr_t rj0,
    input  exe_pkg::reg_addr_t rk0,
    input  exe_pkg::reg_addr_t rj1,
    input  exe_pkg::reg_addr_t rk1,
    input  exe_pkg::word_t     rj_data0,
    input  exe_pkg::word_t     rk_data0,
    input  exe_pkg::word_t     rj_data1,
    input  exe_pkg::word_t     rk_data1,
    exe_fwd_if.sink            s1,
    exe_fwd_if.sink            s2,
    output exe_pkg::word_t     src_a0,
    output exe_pkg::word_t     src_b0,
    output exe_pkg::word_t     src_a1,
    output exe_pkg::word_t     src_b1
);

    // newest result first, lane 1 ahead of lane 0 within a stage
    function automatic exe_pkg::word_t pick(
        input exe_pkg::reg_addr_t idx,
        input exe_pkg::word_t     rf_data,
        input logic               s1_en0,
        input exe_pkg::reg_addr_t s1_rd0,
        input exe_pkg::word_t     s1_data0,
        input logic               s1_en1,
        input exe_pkg::reg_addr_t s1_rd1,
        input exe_pkg::word_t     s1_data1,
        input logic               s2_en0,
        input exe_pkg::reg_addr_t s2_rd0,
        input exe_pkg::word_t     s2_data0,
        input logic               s2_en1,
        input exe_pkg::reg_addr_t s2_rd1,
        input exe_pkg::word_t     s2_data1
    );
        if (idx == '0) begin
            // r0 is hardwired zero
            return '0;
        end else if (s1_en1 && s1_rd1 == idx) begin
            return s1_data1;
        end else if (s1_en0 && s1_rd0 == idx) begin
            return s1_data0;
        end else if (s2_en1 && s2_rd1 == idx) begin
            return s2_data1;
        end else if (s2_en0 && s2_rd0 == idx) begin
            return s2_data0;
        end
        return rf_data;
    endfunction

    always_comb begin
        src_a0 = pick(rj0, rj_data0,
                      s1.en0, s1.rd0, s1.data0, s1.en1, s1.rd1, s1.data1,
                      s2.en0, s2.rd0, s2.data0, s2.en1, s2.rd1, s2.data1);
        src_b0 = pick(rk0, rk_data0,
                      s1.en0, s1.rd0, s1.data0, s1.en1, s1.rd1, s1.data1,
                      s2.en0, s2.rd0, s2.data0, s2.en1, s2.rd1, s2.data1);
        src_a1 = pick(rj1, rj_data1,
                      s1.en0, s1.rd0, s1.data0, s1.en1, s1.rd1, s1.data1,
                      s2.en0, s2.rd0, s2.data0, s2.en1, s2.rd1, s2.data1);
        src_b1 = pick(rk1, rk_data1,
                      s1.en0, s1.rd0, s1.data0, s1.en1, s1.rd1, s1.data1,
                      s2.en0, s2.rd0, s2.data0, s2.en1, s2.rd1, s2.data1);
    end

endmodule

// File: hdl/exe_fwd_if.sv
// results of one pipeline stage, both lanes
interface exe_fwd_if;

    logic                 en0;
    exe_pkg::reg_addr_t   rd0;
    exe_pkg::word_t       data0;

    logic                 en1;
    exe_pkg::reg_addr_t   rd1;
    exe_pkg::word_t       data1;

    modport source (
        output en0, rd0, data0,
        output en1, rd1, data1
    );

    modport sink (
        input en0, rd0, data0,
        input en1, rd1, data1
    );

endinterface

// File: hdl/exe_pkg.sv
package exe_pkg;

    localparam int WORD_BITS = 32;
    localparam int REG_BITS  = 5;

    typedef logic [WORD_BITS-1:0] word_t;
    typedef logic [REG_BITS-1:0]  reg_addr_t;
    typedef logic [3:0]           alu_op_t;
    typedef logic [3:0]           br_cond_t;

    // fall-through step and link offset
    localparam word_t INST_BYTES = 32'd4;

    // low bits of operand b taken as shift amount
    localparam int SHAMT_BITS = 5;

    // alu operation codes
    localparam alu_op_t ALU_ADD  = 4'd0;
    localparam alu_op_t ALU_SUB  = 4'd1;
    localparam alu_op_t ALU_SLT  = 4'd2;
    localparam alu_op_t ALU_SLTU = 4'd3;
    localparam alu_op_t ALU_AND  = 4'd4;
    localparam alu_op_t ALU_OR   = 4'd5;
    localparam alu_op_t ALU_XOR  = 4'd6;
    localparam alu_op_t ALU_NOR  = 4'd7;
    localparam alu_op_t ALU_SLL  = 4'd8;
    localparam alu_op_t ALU_SRL  = 4'd9;
    localparam alu_op_t ALU_SRA  = 4'd10;
    // passes operand b through
    localparam alu_op_t ALU_LUI  = 4'd11;

    // branch kinds
    localparam br_cond_t BR_JIRL = 4'b0011;
    localparam br_cond_t BR_B    = 4'b0100;
    localparam br_cond_t BR_BL   = 4'b0101;
    localparam br_cond_t BR_BEQ  = 4'b0110;
    localparam br_cond_t BR_BNE  = 4'b0111;
    localparam br_cond_t BR_BLT  = 4'b1000;
    localparam br_cond_t BR_BGE  = 4'b1001;
    localparam br_cond_t BR_BLTU = 4'b1010;
    localparam br_cond_t BR_BGEU = 4'b1011;

endpackage
